// ==== compile.f ====
+incdir+src
src/ide_pkg.sv
src/host_bus_if.sv
src/task_file_if.sv
src/host_bus_sync.sv
src/atapi_controller.sv
src/host_read_port.sv
src/ide_device.sv
verif/ide_asserts.sv
verif/tb_ide_device.sv

// ==== Makefile ====
# verilator build and run for the ide device testbench

VERILATOR ?= verilator
TOP       ?= tb_ide_device
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert
EXTRA     ?=

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR TIMESCALE VFLAGS EXTRA"

test:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) $(EXTRA) \
		--top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== verif/tb_ide_device.sv ====
module tb_ide_device;
	timeunit 1ns;
	timeprecision 100ps;

	// register addresses as {cs, da}, chip selects active low
	localparam logic [4:0] reg_data = 5'b10_000;
	localparam logic [4:0] reg_error = 5'b10_001;      // features on write
	localparam logic [4:0] reg_int_reason = 5'b10_010;
	localparam logic [4:0] reg_sector = 5'b10_011;
	localparam logic [4:0] reg_byte_lo = 5'b10_100;
	localparam logic [4:0] reg_byte_hi = 5'b10_101;
	localparam logic [4:0] reg_drive_sel = 5'b10_110;
	localparam logic [4:0] reg_status = 5'b10_111;     // command on write
	localparam logic [4:0] reg_alt_status = 5'b01_110; // cs1 space

	// register values, zero extended as read
	localparam logic [15:0] status_ready = 16'h0050;
	localparam logic [15:0] status_drq = 16'h0058;
	localparam logic [15:0] status_error = 16'h0051;
	localparam logic [15:0] error_abort = 16'h0004;
	localparam logic [15:0] sector_reset = 16'h0081;
	localparam logic [15:0] ireason_out = 16'h0000;
	localparam logic [15:0] ireason_cmd = 16'h0001;
	localparam logic [15:0] ireason_in = 16'h0002;
	localparam logic [15:0] ireason_done = 16'h0003;
	localparam logic [15:0] op_set_features = 16'h00ef;
	localparam logic [15:0] op_device_reset = 16'h0008;
	localparam logic [15:0] op_packet = 16'h00a0;
	localparam logic [15:0] op_invalid = 16'h0055;
	localparam logic [7:0] pkt_test_unit = 8'h00;
	localparam logic [7:0] pkt_test_unit_alt = 8'h70;
	localparam logic [7:0] pkt_req_mode = 8'h11;
	localparam logic [7:0] pkt_set_mode = 8'h12;
	localparam logic [7:0] pkt_cmd71 = 8'h71;
	localparam logic [7:0] rev_addr = 8'h12;

	// about 120 strobes of 12 cycles, doubled for settle waits and margin
	localparam int strobe_cycles = 12;
	localparam int max_cycles = 2 * 120 * strobe_cycles + 120;

	logic clk = 1'b0;
	logic reset;
	logic [1:0] cs;
	logic [2:0] da;
	logic rd, wr;
	logic [15:0] data_in, data_out;
	logic data_oe, intrq;
	int seed = 32'h4c593b70;
	int cycle_count = 0;
	logic [15:0] rev_words [$] = '{16'h6552, 16'h2076, 16'h2e35, 16'h3730}; // "Rev 5.07"
	logic [15:0] cmd71_words [$] = '{16'h06ba, 16'hca0d, 16'h1f6a};

	ide_device dut (
		.clk      (clk),
		.reset    (reset),
		.cs       (cs),
		.da       (da),
		.rd       (rd),
		.wr       (wr),
		.data_in  (data_in),
		.data_out (data_out),
		.data_oe  (data_oe),
		.intrq    (intrq)
	);

	bind atapi_controller ide_asserts u_asserts (
		.clk       (clk),
		.reset     (reset),
		.state     (state),
		.status    (status),
		.command   (command),
		.intrq     (intrq),
		.status_rd (status_rd),
		.word_cnt  (word_cnt)
	);

	always #2 clk = ~clk; // 4 ns period

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles)
		begin
			$display("timeout: the tests did not finish within %0d cycles", max_cycles);
			$display("test failed");
			$fatal(1);
		end
	end

	task automatic check_value(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		if (got !== exp)
		begin
			$display("Error: %s is %h, expected %h", name, got, exp);
			$display("test failed");
			$fatal(1);
		end
	endtask

	// one write strobe, 6 cycles low then 6 high
	task automatic write_reg(input logic [4:0] addr, input logic [15:0] data);
		@(posedge clk);
		cs <= addr[4:3];
		da <= addr[2:0];
		data_in <= data;
		wr <= 1'b0;
		repeat (5) @(posedge clk);
		@(posedge clk);
		wr <= 1'b1; // address and data held through the high phase
		repeat (5) @(posedge clk);
	endtask

	task automatic read_reg(input logic [4:0] addr, output logic [15:0] data,
			output logic oe);
		@(posedge clk);
		cs <= addr[4:3];
		da <= addr[2:0];
		rd <= 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		data = data_out; // settled since the 5th low cycle
		oe = data_oe;
		@(posedge clk);
		rd <= 1'b1;
		repeat (5) @(posedge clk);
	endtask

	task automatic expect_reg(input logic [4:0] addr, input string name,
			input logic [15:0] exp);
		logic [15:0] word;
		logic oe;
		read_reg(addr, word, oe);
		check_value("data_oe", {15'b0, oe}, 16'h0001);
		check_value(name, word, exp);
	endtask

	task automatic check_intrq(input logic exp);
		@(negedge clk);
		check_value("intrq", {15'b0, intrq}, {15'b0, exp});
	endtask

	task automatic settle();
		repeat (10) @(posedge clk);
	endtask

	// packet command, drq check, then six words low byte first
	task automatic send_packet(input logic [7:0] opcode, input logic [7:0] start_addr);
		logic [7:0] pkt [$];
		int i;
		pkt.push_back(opcode);
		pkt.push_back(8'($random(seed))); // flags
		pkt.push_back(start_addr);
		for (i = 3; i < 12; i++)
			pkt.push_back(8'($random(seed)));
		write_reg(reg_status, op_packet);
		expect_reg(reg_status, "status", status_drq);
		expect_reg(reg_int_reason, "int_reason", ireason_cmd);
		for (i = 0; i < 6; i++)
			write_reg(reg_data, {pkt[2 * i + 1], pkt[2 * i]});
	endtask

	task automatic finish_ready();
		settle();
		check_intrq(1'b1);
		expect_reg(reg_status, "status", status_ready); // also clears intrq
		expect_reg(reg_int_reason, "int_reason", ireason_done);
	endtask

	task automatic reset_values();
		@(negedge clk);
		check_value("data_oe", {15'b0, data_oe}, 16'h0000); // bus idle
		check_value("intrq", {15'b0, intrq}, 16'h0000);
		expect_reg(reg_status, "status", status_ready);
		expect_reg(reg_sector, "sector_num", sector_reset);
		expect_reg(reg_error, "error", 16'h0000);
	endtask

	task automatic invalid_command();
		write_reg(reg_status, op_invalid);
		settle();
		check_intrq(1'b1);
		expect_reg(reg_error, "error", error_abort);
		expect_reg(reg_alt_status, "alt_status", status_error);
		check_intrq(1'b1); // alt status leaves it pending
		expect_reg(reg_status, "status", status_error);
		check_intrq(1'b0);
		write_reg(reg_status, op_set_features);
		settle();
		check_intrq(1'b1);
		expect_reg(reg_error, "error", 16'h0000);
		expect_reg(reg_status, "status", status_ready);
		write_reg(reg_byte_lo, 16'ha534); // upper lane not stored
		write_reg(reg_byte_hi, 16'h5a12);
		expect_reg(reg_byte_lo, "byte_lo", 16'h0034);
		expect_reg(reg_byte_hi, "byte_hi", 16'h0012);
	endtask

	task automatic packet_test_unit();
		send_packet(pkt_test_unit, 8'($random(seed)));
		finish_ready();
		send_packet(pkt_test_unit_alt, 8'($random(seed)));
		finish_ready();
	endtask

	task automatic req_mode_reply();
		logic [7:0] other_addr;
		int i;
		send_packet(pkt_req_mode, rev_addr);
		settle();
		check_intrq(1'b1);
		expect_reg(reg_int_reason, "int_reason", ireason_in);
		expect_reg(reg_status, "status", status_drq);
		foreach (rev_words[i])
			expect_reg(reg_data, "data", rev_words[i]);
		finish_ready();
		other_addr = 8'($random(seed));
		if (other_addr == rev_addr)
			other_addr = other_addr ^ 8'h01; // any other start gives zeros
		send_packet(pkt_req_mode, other_addr);
		settle();
		for (i = 0; i < 5; i++)
			expect_reg(reg_data, "data", 16'h0000);
		finish_ready();
	endtask

	task automatic cmd71_and_set_mode();
		int i;
		send_packet(pkt_cmd71, 8'($random(seed)));
		settle();
		expect_reg(reg_int_reason, "int_reason", ireason_in);
		foreach (cmd71_words[i])
			expect_reg(reg_data, "data", cmd71_words[i]);
		finish_ready();
		send_packet(pkt_set_mode, 8'($random(seed)));
		settle();
		expect_reg(reg_int_reason, "int_reason", ireason_out);
		expect_reg(reg_status, "status", status_drq);
		for (i = 0; i < 5; i++)
			write_reg(reg_data, 16'($random(seed)));
		finish_ready();
	endtask

	task automatic drive_select();
		logic [15:0] word;
		logic oe;
		write_reg(reg_drive_sel, 16'h0010); // bit 4, other drive
		read_reg(reg_status, word, oe);
		check_value("data_oe", {15'b0, oe}, 16'h0000);
		read_reg(reg_alt_status, word, oe);
		check_value("data_oe", {15'b0, oe}, 16'h0000);
		write_reg(reg_status, op_invalid); // not for this drive
		settle();
		write_reg(reg_drive_sel, 16'h0000);
		expect_reg(reg_error, "error", 16'h0000);
		expect_reg(reg_status, "status", status_ready);
		write_reg(reg_status, op_set_features);
		settle();
		check_intrq(1'b1);
		write_reg(reg_status, op_device_reset);
		settle();
		check_intrq(1'b0); // reset drops it without a status read
		expect_reg(reg_status, "status", status_ready);
		expect_reg(reg_sector, "sector_num", sector_reset);
		expect_reg(reg_byte_lo, "byte_lo", 16'h0000);
	endtask

	initial
	begin
		reset = 1'b1;
		cs = 2'b11; // neither chip select
		da = 3'd0;
		rd = 1'b1;
		wr = 1'b1;
		data_in = 16'h0000;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		reset_values();
		invalid_command();
		packet_test_unit();
		req_mode_reply();
		cmd71_and_set_mode();
		drive_select();
		$display("test passed");
		$finish;
	end

endmodule

// ==== verif/ide_asserts.sv ====
`include "ide_settings.svh"

module ide_asserts #(
	parameter logic [2:0] idle_state = 3'd0,    // fsm encoding of the controller
	parameter logic [2:0] command_state = 3'd1
) (
	input logic clk,
	input logic reset,
	input logic [2:0] state,
	input logic [7:0] status,
	input logic [7:0] command,
	input logic intrq,
	input logic status_rd,
	input logic [2:0] word_cnt
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [2:0] max_words = 3'(`IDE_PACKET_BYTES / 2);

	logic dev_reset_run; // device reset executing this cycle

	assign dev_reset_run = (state == command_state) && (command == `IDE_CMD_DEVICE_RESET);

	// bsy is bit 7, drq bit 3, an idle fsm shows neither
	idle_busy_drq: assert property (@(posedge clk) disable iff (reset)
		(state == idle_state) |-> !(status[7] || status[3]))
		else $error("busy or drq set while the fsm is idle");

	// only a status read, device reset or reset drops the interrupt
	intrq_fall: assert property (@(posedge clk) disable iff (reset)
		$fell(intrq) |-> $past(status_rd || dev_reset_run || reset))
		else $error("intrq fell without a status read or reset");

	packet_count: assert property (@(posedge clk) disable iff (reset)
		word_cnt <= max_words)
		else $error("word count beyond six");

endmodule

// ==== src/ide_device.sv ====
`include "ide_settings.svh"

module ide_device (
	input logic clk,
	input logic reset,
	input logic [1:0] cs,              // active low chip selects
	input logic [2:0] da,
	input logic rd,                    // active low strobes
	input logic wr,
	input logic [`IDE_DATA_W-1:0] data_in,
	output logic [`IDE_DATA_W-1:0] data_out,
	output logic data_oe,              // enables the external bus driver
	output logic intrq
);

	host_bus_if bus_if ();
	task_file_if tf_if ();

	// strobes and address into the clock domain
	host_bus_sync u_bus_sync (
		.clk     (clk),
		.reset   (reset),
		.cs      (cs),
		.da      (da),
		.rd      (rd),
		.wr      (wr),
		.data_in (data_in),
		.bus     (bus_if.sync)
	);

	atapi_controller u_ctrl (
		.clk   (clk),
		.reset (reset),
		.bus   (bus_if.sink),
		.regs  (tf_if.ctrl)
	);

	host_read_port u_read_port (
		.clk      (clk),
		.reset    (reset),
		.bus      (bus_if.sink),
		.regs     (tf_if.port),
		.data_out (data_out),
		.data_oe  (data_oe)
	);

	assign intrq = tf_if.intrq;

endmodule

// ==== src/host_read_port.sv ====
`include "ide_settings.svh"

module host_read_port (
	input logic clk,
	input logic reset,
	host_bus_if.sink bus,
	task_file_if.port regs,
	output logic [`IDE_DATA_W-1:0] data_out,
	output logic [0:0] data_oe
);
	import ide_pkg::*;

	localparam int PAD_W = `IDE_DATA_W - 8; // byte registers sit in the low lane

	logic [`IDE_DATA_W-1:0] mux_word;

	always_comb
	begin
		case (bus.sel)
			sel_alt_status, sel_status: mux_word = {{PAD_W{1'b0}}, regs.status};
			sel_data: mux_word = regs.pio_word;
			sel_error: mux_word = {{PAD_W{1'b0}}, regs.error};
			sel_int_reason: mux_word = {{PAD_W{1'b0}}, regs.int_reason};
			sel_sector_num: mux_word = {{PAD_W{1'b0}}, regs.sector_num};
			sel_byte_lo: mux_word = {{PAD_W{1'b0}}, regs.byte_count[7:0]};
			sel_byte_hi: mux_word = {{PAD_W{1'b0}}, regs.byte_count[15:8]};
			sel_drive_sel: mux_word = {{PAD_W{1'b0}}, regs.drive_sel};
			default: mux_word = '0; // unmapped address
		endcase
	end

	// registered so the word is stable well before rd rises
	always_ff @(posedge clk)
	begin
		if (reset)
			data_out <= '0;
		else
			data_out <= mux_word;
	end

	// every mapped register is readable
	assign data_oe = bus.rd_active && (bus.sel != sel_none) && regs.selected;

endmodule

// ==== src/atapi_controller.sv ====
`include "ide_settings.svh"

module atapi_controller (
	input logic clk,
	input logic reset,
	host_bus_if.sink bus,
	task_file_if.ctrl regs
);
	import ide_pkg::*;

	localparam int PACKET_WORDS = `IDE_PACKET_BYTES / 2;
	localparam logic [2:0] LAST_PKT_WORD = 3'(PACKET_WORDS - 1);
	localparam logic [2:0] LAST_SET_MODE_WORD = 3'(`IDE_SET_MODE_WORDS - 1);

	// command fsm
	localparam logic [2:0] st_idle = 3'd0;
	localparam logic [2:0] st_command = 3'd1;     // decode the ata opcode
	localparam logic [2:0] st_packet_rx = 3'd2;   // collect six words
	localparam logic [2:0] st_dispatch = 3'd3;    // decode the packet opcode
	localparam logic [2:0] st_reply_tx = 3'd4;
	localparam logic [2:0] st_set_mode_rx = 3'd5;
	localparam logic [2:0] st_finish = 3'd6;
	localparam logic [2:0] st_abort = 3'd7;

	localparam logic [1:0] reply_zeros = 2'd0;
	localparam logic [1:0] reply_rev = 2'd1;
	localparam logic [1:0] reply_cmd71 = 2'd2;

	logic [2:0] state;
	logic [7:0] status;
	logic [7:0] error_reg;
	logic [7:0] features;
	logic [7:0] int_reason;
	logic [7:0] drive_sel;
	logic [7:0] command;
	logic [15:0] byte_count;
	logic nien;                       // host masks the interrupt pin
	logic intrq;
	logic [2:0] word_cnt;             // packet word, reply index or set_mode word
	logic [2:0] reply_last;           // index of the final reply word
	logic [1:0] reply_kind;
	logic [`IDE_DATA_W-1:0] pio_word;
	packet_t packet;
	logic selected;
	logic data_wr, data_rd, status_rd;

	function automatic logic [`IDE_DATA_W-1:0] reply_word(input logic [1:0] kind,
			input logic [2:0] idx);
		logic [`IDE_DATA_W-1:0] w;
		w = '0; // zero reply and past the end
		if (kind == reply_rev)
		begin
			case (idx)
				3'd0: w = `IDE_REV_WORD0;
				3'd1: w = `IDE_REV_WORD1;
				3'd2: w = `IDE_REV_WORD2;
				3'd3: w = `IDE_REV_WORD3;
				default: w = '0;
			endcase
		end
		else if (kind == reply_cmd71)
		begin
			case (idx)
				3'd0: w = `IDE_CMD71_WORD0;
				3'd1: w = `IDE_CMD71_WORD1;
				3'd2: w = `IDE_CMD71_WORD2;
				default: w = '0;
			endcase
		end
		return w;
	endfunction

	assign selected = ~drive_sel[`IDE_DRV_BIT];
	assign data_wr = bus.wr_pulse && (bus.sel == sel_data) && selected;
	assign data_rd = bus.rd_pulse && (bus.sel == sel_data) && selected;
	assign status_rd = bus.rd_pulse && (bus.sel == sel_status) && selected;

	// packet bytes, low byte of each word first
	always_ff @(posedge clk)
	begin
		if ((state == st_packet_rx) && data_wr)
		begin
			packet.raw[{word_cnt, 1'b0}] <= bus.wr_data[7:0];
			packet.raw[{word_cnt, 1'b1}] <= bus.wr_data[15:8];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= st_idle;
			status <= `IDE_STATUS_READY;
			error_reg <= '0;
			features <= '0;
			int_reason <= '0;
			drive_sel <= '0;
			command <= '0;
			byte_count <= '0;
			nien <= 1'b0;
			intrq <= 1'b0;
			word_cnt <= '0;
			pio_word <= '0;
		end
		else
		begin
			if (status_rd)
				intrq <= 1'b0; // alt status read leaves it set
			case (state)
				st_command:
				begin
					case (command)
						`IDE_CMD_SET_FEATURES:
						begin
							error_reg <= '0;
							status <= `IDE_STATUS_READY;
							intrq <= 1'b1;
							state <= st_idle;
						end
						`IDE_CMD_DEVICE_RESET:
						begin
							status <= `IDE_STATUS_READY;
							error_reg <= '0;
							features <= '0;
							int_reason <= '0;
							drive_sel <= '0;
							byte_count <= '0;
							nien <= 1'b0;
							intrq <= 1'b0;
							state <= st_idle;
						end
						`IDE_CMD_PACKET:
						begin
							int_reason <= `IDE_IREASON_CMD;
							status <= `IDE_STATUS_DRQ;
							word_cnt <= '0;
							// no dma engine, so a dma packet is refused
							state <= features[`IDE_FEAT_DMA_BIT] ? st_abort : st_packet_rx;
						end
						default: state <= st_abort;
					endcase
				end
				st_packet_rx:
				begin
					if (data_wr)
					begin
						word_cnt <= word_cnt + 3'd1;
						if (word_cnt == LAST_PKT_WORD)
						begin
							status <= `IDE_STATUS_BUSY; // drq drops, bsy while decoding
							state <= st_dispatch;
						end
					end
				end
				st_dispatch:
				begin
					word_cnt <= '0;
					case (packet.fields.opcode)
						`IDE_PKT_TEST_UNIT, `IDE_PKT_TEST_UNIT_ALT: state <= st_finish;
						`IDE_PKT_REQ_MODE:
						begin
							status <= `IDE_STATUS_DRQ;
							int_reason <= `IDE_IREASON_DATA_IN;
							intrq <= 1'b1;
							state <= st_reply_tx;
							if (packet.fields.start_addr == `IDE_REQ_MODE_REV_ADDR)
							begin
								reply_kind <= reply_rev;
								reply_last <= 3'd3; // four words of text
								byte_count <= 16'd8;
								pio_word <= `IDE_REV_WORD0;
							end
							else
							begin
								reply_kind <= reply_zeros;
								reply_last <= 3'd4;
								byte_count <= 16'd10;
								pio_word <= '0;
							end
						end
						`IDE_PKT_CMD71:
						begin
							status <= `IDE_STATUS_DRQ;
							int_reason <= `IDE_IREASON_DATA_IN;
							intrq <= 1'b1;
							reply_kind <= reply_cmd71;
							reply_last <= 3'd2;
							byte_count <= 16'd6;
							pio_word <= `IDE_CMD71_WORD0;
							state <= st_reply_tx;
						end
						`IDE_PKT_SET_MODE:
						begin
							status <= `IDE_STATUS_DRQ;
							int_reason <= `IDE_IREASON_DATA_OUT;
							intrq <= 1'b1;
							byte_count <= 16'd10;
							state <= st_set_mode_rx;
						end
						default: state <= st_abort; // unsupported packet opcode
					endcase
				end
				st_reply_tx:
				begin
					if (data_rd)
					begin
						if (word_cnt == reply_last)
							state <= st_finish;
						else
						begin
							word_cnt <= word_cnt + 3'd1;
							pio_word <= reply_word(reply_kind, word_cnt + 3'd1);
						end
					end
				end
				st_set_mode_rx:
				begin
					if (data_wr)
					begin
						word_cnt <= word_cnt + 3'd1; // mode words are consumed
						if (word_cnt == LAST_SET_MODE_WORD)
							state <= st_finish;
					end
				end
				st_finish:
				begin
					status <= `IDE_STATUS_READY;
					error_reg <= '0;
					int_reason <= `IDE_IREASON_DONE;
					intrq <= 1'b1;
					pio_word <= '0;
					state <= st_idle;
				end
				st_abort:
				begin
					error_reg <= `IDE_ERROR_ABORT;
					status <= `IDE_STATUS_ERROR;
					int_reason <= `IDE_IREASON_DONE;
					intrq <= 1'b1;
					state <= st_idle;
				end
				default: state <= st_idle; // idle waits for a command write
			endcase

			// drive select stays writable so the host can reselect
			if (bus.wr_pulse && (selected || (bus.sel == sel_drive_sel)))
			begin
				case (bus.sel)
					sel_alt_status: nien <= bus.wr_data[`IDE_NIEN_BIT];
					sel_error: features <= bus.wr_data[7:0];
					sel_int_reason: int_reason <= bus.wr_data[7:0];
					sel_byte_lo: byte_count[7:0] <= bus.wr_data[7:0];
					sel_byte_hi: byte_count[15:8] <= bus.wr_data[7:0];
					sel_drive_sel: drive_sel <= bus.wr_data[7:0];
					sel_status:
					begin
						command <= bus.wr_data[7:0];
						status <= `IDE_STATUS_BUSY;
						state <= st_command; // a new command overrides the fsm
					end
					default: ;
				endcase
			end
		end
	end

	assign regs.status = status;
	assign regs.error = error_reg;
	assign regs.int_reason = int_reason;
	assign regs.sector_num = `IDE_SECTOR_NUM_RESET; // disc format byte, fixed
	assign regs.byte_count = byte_count;
	assign regs.drive_sel = drive_sel;
	assign regs.pio_word = pio_word;
	assign regs.selected = selected;
	assign regs.intrq = intrq & selected & ~nien; // pin quiet when deselected
endmodule

// ==== src/host_bus_sync.sv ====
`include "ide_settings.svh"

module host_bus_sync (
	input logic clk,
	input logic reset,
	input logic [1:0] cs,
	input logic [2:0] da,
	input logic rd,
	input logic wr,
	input logic [`IDE_DATA_W-1:0] data_in,
	host_bus_if.sync bus
);
	import ide_pkg::*;

	logic rd_s1, rd_s2, rd_d; // two sync flops, then edge flop
	logic wr_s1, wr_s2, wr_d;
	logic [4:0] addr_s1, addr_s2; // {cs[0], cs[1], da}, same depth as strobes
	logic [`IDE_DATA_W-1:0] data_hold;
	reg_sel_t sel_next;

	// cs1 space holds only alt status, cs0 space the full task file
	always_comb
	begin
		case (addr_s2)
			5'b10110: sel_next = sel_alt_status;
			5'b01000: sel_next = sel_data;
			5'b01001: sel_next = sel_error;
			5'b01010: sel_next = sel_int_reason;
			5'b01011: sel_next = sel_sector_num;
			5'b01100: sel_next = sel_byte_lo;
			5'b01101: sel_next = sel_byte_hi;
			5'b01110: sel_next = sel_drive_sel;
			5'b01111: sel_next = sel_status;
			default: sel_next = sel_none; // both or neither cs, or unmapped
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_s1 <= 1'b1; // strobes idle high
			rd_s2 <= 1'b1;
			rd_d <= 1'b1;
			wr_s1 <= 1'b1;
			wr_s2 <= 1'b1;
			wr_d <= 1'b1;
			bus.rd_pulse <= 1'b0;
			bus.wr_pulse <= 1'b0;
			bus.rd_active <= 1'b0;
			bus.sel <= sel_none;
		end
		else
		begin
			rd_s1 <= rd;
			rd_s2 <= rd_s1;
			rd_d <= rd_s2;
			wr_s1 <= wr;
			wr_s2 <= wr_s1;
			wr_d <= wr_s2;
			bus.rd_pulse <= rd_s2 & ~rd_d; // act on the rising edge
			bus.wr_pulse <= wr_s2 & ~wr_d;
			bus.rd_active <= ~rd_s2;
			bus.sel <= sel_next;
		end
	end

	always_ff @(posedge clk)
	begin
		addr_s1 <= {cs[0], cs[1], da};
		addr_s2 <= addr_s1;
		if (!wr)
			data_hold <= data_in; // last sample while the strobe is low
		if (wr_s2 && !wr_d)
			bus.wr_data <= data_hold; // lines up with wr_pulse
	end

endmodule

// ==== src/task_file_if.sv ====
`include "ide_settings.svh"

// task file contents toward the read port
interface task_file_if;
	logic [7:0] status;
	logic [7:0] error;
	logic [7:0] int_reason;
	logic [7:0] sector_num;
	logic [15:0] byte_count;
	logic [7:0] drive_sel;
	logic [`IDE_DATA_W-1:0] pio_word; // word the next data read returns
	logic selected;                   // drive select bit clear
	logic intrq;                      // masked level for the pin

	modport ctrl (
		output status, error, int_reason, sector_num, byte_count, drive_sel,
		output pio_word, selected, intrq
	);

	modport port (
		input status, error, int_reason, sector_num, byte_count, drive_sel,
		input pio_word, selected
	);

endinterface

// ==== src/host_bus_if.sv ====
`include "ide_settings.svh"

// decoded host accesses, input side to the rest of the device
interface host_bus_if;
	import ide_pkg::*;

	reg_sel_t sel;                    // register under cs and da
	logic wr_pulse;                   // one cycle per write strobe
	logic rd_pulse;                   // one cycle per read strobe
	logic rd_active;                  // read strobe is held low
	logic [`IDE_DATA_W-1:0] wr_data;  // word of the last write

	modport sync (
		output sel, wr_pulse, rd_pulse, rd_active, wr_data
	);

	modport sink (
		input sel, wr_pulse, rd_pulse, rd_active, wr_data
	);

endinterface

// ==== src/ide_pkg.sv ====
`include "ide_settings.svh"

package ide_pkg;

	// register picked by {cs, da}, named by its read meaning
	typedef enum logic [3:0] {
		sel_none,
		sel_alt_status, // device control on write
		sel_data,
		sel_error,      // features on write
		sel_int_reason,
		sel_sector_num,
		sel_byte_lo,
		sel_byte_hi,
		sel_drive_sel,
		sel_status      // command on write
	} reg_sel_t;

	// one packet, filled bytewise and decoded by field
	typedef union packed {
		logic [`IDE_PACKET_BYTES-1:0][7:0] raw; // raw[0] is the first byte on the bus
		struct packed {
			logic [`IDE_PACKET_BYTES-4:0][7:0] params; // bytes 3 to 11
			logic [7:0] start_addr;                     // byte 2
			logic [7:0] flags;                          // byte 1
			logic [7:0] opcode;                         // byte 0
		} fields;
	} packet_t;

endpackage

// ==== src/ide_settings.svh ====
`ifndef IDE_SETTINGS_SVH
`define IDE_SETTINGS_SVH

// bus geometry
`define IDE_DATA_W          16
`define IDE_PACKET_BYTES    12    // six words per packet
`define IDE_SET_MODE_WORDS  5

// status register values
`define IDE_STATUS_READY    8'h50 // drdy and dsc
`define IDE_STATUS_DRQ      8'h58 // ready plus data request
`define IDE_STATUS_ERROR    8'h51 // ready plus check
`define IDE_STATUS_BUSY     8'hd0 // bsy while a command runs

`define IDE_SECTOR_NUM_RESET 8'h81 // upper nibble 8 marks a gd-rom format
`define IDE_ERROR_ABORT      8'h04

// interrupt reason values {io, cod}
`define IDE_IREASON_DATA_OUT 8'h00 // host to device
`define IDE_IREASON_CMD      8'h01 // packet expected
`define IDE_IREASON_DATA_IN  8'h02 // device to host
`define IDE_IREASON_DONE     8'h03

// bit positions in control registers
`define IDE_DRV_BIT      4 // drive select, device answers only when clear
`define IDE_NIEN_BIT     1 // device control interrupt mask
`define IDE_FEAT_DMA_BIT 0 // features dma request for packet

// ata opcodes
`define IDE_CMD_SET_FEATURES 8'hef
`define IDE_CMD_DEVICE_RESET 8'h08
`define IDE_CMD_PACKET       8'ha0

// packet opcodes
`define IDE_PKT_TEST_UNIT     8'h00
`define IDE_PKT_TEST_UNIT_ALT 8'h70
`define IDE_PKT_REQ_MODE      8'h11
`define IDE_PKT_SET_MODE      8'h12
`define IDE_PKT_CMD71         8'h71
`define IDE_REQ_MODE_REV_ADDR 8'h12 // start address of the revision string

// reply words
`define IDE_REV_WORD0   16'h6552 // "Re"
`define IDE_REV_WORD1   16'h2076 // "v "
`define IDE_REV_WORD2   16'h2e35 // "5."
`define IDE_REV_WORD3   16'h3730 // "07"
`define IDE_CMD71_WORD0 16'h06ba
`define IDE_CMD71_WORD1 16'hca0d
`define IDE_CMD71_WORD2 16'h1f6a

`endif
